// File: hdl/mg_pkg.sv
package mg_pkg;

    //////////////////////////////
    // Register word layout
    //////////////////////////////

    // Register address, word 0 is status and words 1 to 12 are cards
    typedef logic [3:0] addr_t;

    // One 14-bit register word with two views
    typedef union packed {
        // Card view at addresses 1 to 12
        struct packed {
            logic [11:0] colour;
            logic        discovered;
            logic        active;
        } card;
        // Status view at address 0
        struct packed {
            logic [7:0] moves;
            logic [3:0] pairs;
            logic [1:0] reserved;
        } status;
    } reg_word_t;

    //////////////////////////////
    // Board constants
    //////////////////////////////

    // Card colours as 4-bit r, g, b
    localparam logic [11:0] colour_red     = 12'hf00;
    localparam logic [11:0] colour_green   = 12'h0f0;
    localparam logic [11:0] colour_blue    = 12'h00f;
    localparam logic [11:0] colour_yellow  = 12'hff0;
    localparam logic [11:0] colour_magenta = 12'hf0f;
    localparam logic [11:0] colour_mint    = 12'h0aa;

    // Dealer LFSR start value after reset
    localparam logic [3:0] lfsr_seed = 4'd8;

    // Highest card address, also the number of cards
    localparam addr_t num_cards = 4'd12;
    // Pairs on the board, game ends when all are found
    localparam logic [3:0] num_pairs = 4'd6;
    // Move counter stops here
    localparam logic [7:0] moves_max = 8'hff;

    //////////////////////////////
    // Pick results and controller states
    //////////////////////////////

    localparam logic [1:0] pick_rejected = 2'd0;
    localparam logic [1:0] pick_first    = 2'd1;
    localparam logic [1:0] pick_match    = 2'd2;
    localparam logic [1:0] pick_mismatch = 2'd3;

    // Pick FSM, one state per stage of the three cycle pick
    localparam logic [2:0] st_idle   = 3'd0;
    localparam logic [2:0] st_read   = 3'd1;
    localparam logic [2:0] st_pair   = 3'd2;
    localparam logic [2:0] st_status = 3'd3;
    localparam logic [2:0] st_ack    = 3'd4;

endpackage

// File: hdl/card_dealer.sv
module card_dealer (
    input  logic              clk,
    input  logic              rst,
    input  logic              start,
    output logic              busy,
    output logic              deal_we,
    output mg_pkg::addr_t     deal_addr,
    output mg_pkg::reg_word_t deal_data
);

    // Free running shuffle source
    logic [3:0] lfsr;
    // Cards written so far in this deal
    mg_pkg::addr_t count;
    // Colour of the pair picked by the current LFSR value
    logic [11:0] pair_colour;

    //////////////////////////////
    // LFSR and deal sequencing
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            lfsr  <= mg_pkg::lfsr_seed;
            busy  <= 1'b0;
            count <= '0;
        end else begin
            // Shift right, bit0 xor bit1 feeds bit3
            lfsr <= {lfsr[0] ^ lfsr[1], lfsr[3:1]};
            if (start) begin
                // New game restarts the deal from card 1
                busy  <= 1'b1;
                count <= '0;
            end else if (deal_we) begin
                if (count == mg_pkg::num_cards - 4'd1) begin
                    // Twelfth card written, deal done
                    busy  <= 1'b0;
                    count <= '0;
                end else begin
                    count <= count + 4'd1;
                end
            end
        end
    end

    // Values 13 to 15 are skipped, so a deal takes 12 to 15 cycles
    assign deal_we = busy && (lfsr >= 4'd1) && (lfsr <= mg_pkg::num_cards);

    // Word 0 is status, cards start at address 1
    assign deal_addr = count + 4'd1;

    //////////////////////////////
    // Pair table
    //////////////////////////////

    always_comb begin
        case (lfsr)
            4'd1, 4'd2:   pair_colour = mg_pkg::colour_green;
            4'd3, 4'd4:   pair_colour = mg_pkg::colour_yellow;
            4'd5, 4'd6:   pair_colour = mg_pkg::colour_red;
            4'd7, 4'd8:   pair_colour = mg_pkg::colour_blue;
            4'd9, 4'd10:  pair_colour = mg_pkg::colour_magenta;
            4'd11, 4'd12: pair_colour = mg_pkg::colour_mint;
            // No write for these values
            default:      pair_colour = 12'h000;
        endcase
    end

    // Dealt card is covered and active
    always_comb begin
        deal_data                 = '0;
        deal_data.card.colour     = pair_colour;
        deal_data.card.discovered = 1'b0;
        deal_data.card.active     = 1'b1;
    end

endmodule

// File: hdl/card_regfile.sv
module card_regfile (
    input  logic              clk,
    input  logic              rst,
    // Dealer write port
    input  logic              deal_we,
    input  mg_pkg::addr_t     deal_addr,
    input  mg_pkg::reg_word_t deal_data,
    // Controller write port
    input  logic              ctl_we,
    input  mg_pkg::addr_t     ctl_addr,
    input  mg_pkg::reg_word_t ctl_data,
    // Controller read address
    input  mg_pkg::addr_t     ctl_raddr,
    // Display read address
    input  mg_pkg::addr_t     view_addr,
    output mg_pkg::reg_word_t ctl_rdata,
    output mg_pkg::reg_word_t view_data
);

    // Word 0 status, words 1 to 12 cards
    mg_pkg::reg_word_t words [0:mg_pkg::num_cards];

    //////////////////////////////
    // Write ports
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            // Empty board, every card inactive
            for (int i = 0; i <= mg_pkg::num_cards; i++) begin
                words[i] <= '0;
            end
        end else begin
            // Dealer and controller never hit the same word in one cycle
            if (deal_we && (deal_addr <= mg_pkg::num_cards)) begin
                words[deal_addr] <= deal_data;
            end
            if (ctl_we && (ctl_addr <= mg_pkg::num_cards)) begin
                words[ctl_addr] <= ctl_data;
            end
        end
    end

    //////////////////////////////
    // Read ports
    //////////////////////////////

    // Controller read, combinational
    always_comb begin
        if (ctl_raddr <= mg_pkg::num_cards) begin
            ctl_rdata = words[ctl_raddr];
        end else begin
            // Addresses 13 to 15 read as zero
            ctl_rdata = '0;
        end
    end

    // Display read, combinational
    always_comb begin
        if (view_addr <= mg_pkg::num_cards) begin
            view_data = words[view_addr];
        end else begin
            view_data = '0;
        end
    end

endmodule

// File: hdl/game_control.sv
module game_control (
    input  logic              clk,
    input  logic              rst,
    input  logic              new_game,
    input  logic              dealing,
    // Pick handshake
    input  logic              pick_req,
    input  mg_pkg::addr_t     pick_index,
    output logic              pick_ack,
    output logic [1:0]        pick_result,
    // Register file access
    output logic              ctl_we,
    output mg_pkg::addr_t     ctl_addr,
    output mg_pkg::addr_t     ctl_raddr,
    output mg_pkg::reg_word_t ctl_data,
    input  mg_pkg::reg_word_t ctl_rdata,
    output logic              game_over
);

    logic [2:0]    state;
    // Registered outcome of the pick in progress
    logic [1:0]    result_q;
    // Outcome decided from the card read in st_read
    logic [1:0]    res_c;
    // Index of the pick in progress
    mg_pkg::addr_t idx;
    // First card of the current pair
    logic          have_first;
    mg_pkg::addr_t first_idx;
    logic [11:0]   first_colour;
    // Copy of the status word
    logic [7:0]    moves_q;
    logic [3:0]    pairs_q;
    logic          in_range;
    logic          same_as_first;

    //////////////////////////////
    // Pick decision
    //////////////////////////////

    always_comb begin
        in_range      = (idx >= 4'd1) && (idx <= mg_pkg::num_cards);
        same_as_first = have_first && (idx == first_idx);
        if (!in_range || !ctl_rdata.card.active || same_as_first) begin
            res_c = mg_pkg::pick_rejected;
        end else if (!have_first) begin
            res_c = mg_pkg::pick_first;
        end else if (ctl_rdata.card.colour == first_colour) begin
            res_c = mg_pkg::pick_match;
        end else begin
            res_c = mg_pkg::pick_mismatch;
        end
    end

    // Picked card is always the one read
    assign ctl_raddr = idx;

    //////////////////////////////
    // Register writes
    //////////////////////////////

    // One write per pick stage: picked card, first card, status word
    always_comb begin
        ctl_we   = 1'b0;
        ctl_addr = '0;
        ctl_data = '0;
        if (new_game) begin
            // Clear moves and pairs on the same edge the deal starts
            ctl_we = 1'b1;
        end else begin
            case (state)
                mg_pkg::st_read: begin
                    if (res_c != mg_pkg::pick_rejected) begin
                        ctl_we                   = 1'b1;
                        ctl_addr                 = idx;
                        ctl_data                 = ctl_rdata;
                        // Uncovered unless a mismatch, removed on a match
                        ctl_data.card.discovered = (res_c != mg_pkg::pick_mismatch);
                        ctl_data.card.active     = (res_c != mg_pkg::pick_match);
                    end
                end
                mg_pkg::st_pair: begin
                    // Second pick also settles the first card
                    if ((result_q == mg_pkg::pick_match) ||
                        (result_q == mg_pkg::pick_mismatch)) begin
                        ctl_we                   = 1'b1;
                        ctl_addr                 = first_idx;
                        ctl_data.card.colour     = first_colour;
                        ctl_data.card.discovered = (result_q == mg_pkg::pick_match);
                        ctl_data.card.active     = (result_q != mg_pkg::pick_match);
                    end
                end
                mg_pkg::st_status: begin
                    if ((result_q == mg_pkg::pick_match) ||
                        (result_q == mg_pkg::pick_mismatch)) begin
                        ctl_we                 = 1'b1;
                        ctl_addr               = '0;
                        ctl_data.status.moves  = moves_q;
                        ctl_data.status.pairs  = pairs_q;
                    end
                end
                default: ctl_we = 1'b0;
            endcase
        end
    end

    //////////////////////////////
    // Pick FSM and status
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= mg_pkg::st_idle;
            pick_ack   <= 1'b0;
            result_q   <= mg_pkg::pick_rejected;
            have_first <= 1'b0;
            moves_q    <= '0;
            pairs_q    <= '0;
        end else begin
            case (state)
                mg_pkg::st_idle: begin
                    // Picks wait while the board is being dealt
                    if (pick_req && !dealing && !new_game) begin
                        state <= mg_pkg::st_read;
                    end
                end
                mg_pkg::st_read: begin
                    result_q <= res_c;
                    state    <= mg_pkg::st_pair;
                    if (res_c == mg_pkg::pick_first) begin
                        have_first <= 1'b1;
                    end else if (res_c != mg_pkg::pick_rejected) begin
                        // Pair closed, count the move
                        have_first <= 1'b0;
                        if (moves_q != mg_pkg::moves_max) begin
                            moves_q <= moves_q + 8'd1;
                        end
                        if (res_c == mg_pkg::pick_match) begin
                            pairs_q <= pairs_q + 4'd1;
                        end
                    end
                end
                mg_pkg::st_pair: state <= mg_pkg::st_status;
                mg_pkg::st_status: begin
                    // Ack three cycles after req was taken
                    pick_ack <= 1'b1;
                    state    <= mg_pkg::st_ack;
                end
                mg_pkg::st_ack: begin
                    // Hold ack until the player drops req
                    if (!pick_req) begin
                        pick_ack <= 1'b0;
                        state    <= mg_pkg::st_idle;
                    end
                end
                default: state <= mg_pkg::st_idle;
            endcase
            if (new_game) begin
                moves_q    <= '0;
                pairs_q    <= '0;
                have_first <= 1'b0;
                // A pick in flight is answered but has no effect
                if ((state == mg_pkg::st_read) || (state == mg_pkg::st_pair) ||
                    (state == mg_pkg::st_status)) begin
                    result_q <= mg_pkg::pick_rejected;
                end
            end
        end
    end

    // Pick payload
    always_ff @(posedge clk) begin
        if ((state == mg_pkg::st_idle) && pick_req) begin
            idx <= pick_index;
        end
        if ((state == mg_pkg::st_read) && (res_c == mg_pkg::pick_first)) begin
            first_idx    <= idx;
            first_colour <= ctl_rdata.card.colour;
        end
    end

    assign pick_result = result_q;
    assign game_over   = (pairs_q == mg_pkg::num_pairs);

endmodule

// File: hdl/memory_game_top.sv
module memory_game_top (
    input  logic              clk,
    input  logic              rst,
    input  logic              new_game,
    input  logic              pick_req,
    input  mg_pkg::addr_t     pick_index,
    input  mg_pkg::addr_t     view_addr,
    output logic              pick_ack,
    output logic [1:0]        pick_result,
    output logic              dealing,
    output mg_pkg::reg_word_t view_data,
    output logic              game_over
);

    // Dealer write port
    logic              deal_we;
    mg_pkg::addr_t     deal_addr;
    mg_pkg::reg_word_t deal_data;

    // Controller ports
    logic              ctl_we;
    mg_pkg::addr_t     ctl_addr;
    mg_pkg::addr_t     ctl_raddr;
    mg_pkg::reg_word_t ctl_data;
    mg_pkg::reg_word_t ctl_rdata;

    //////////////////////////////
    // Blocks
    //////////////////////////////

    // Shuffles a fresh board on every new game
    card_dealer u_dealer (
        .clk       (clk),
        .rst       (rst),
        .start     (new_game),
        .busy      (dealing),
        .deal_we   (deal_we),
        .deal_addr (deal_addr),
        .deal_data (deal_data)
    );

    card_regfile u_regfile (
        .clk       (clk),
        .rst       (rst),
        .deal_we   (deal_we),
        .deal_addr (deal_addr),
        .deal_data (deal_data),
        .ctl_we    (ctl_we),
        .ctl_addr  (ctl_addr),
        .ctl_data  (ctl_data),
        .ctl_raddr (ctl_raddr),
        .view_addr (view_addr),
        .ctl_rdata (ctl_rdata),
        .view_data (view_data)
    );

    // Pick handling and scoring
    game_control u_control (
        .clk         (clk),
        .rst         (rst),
        .new_game    (new_game),
        .dealing     (dealing),
        .pick_req    (pick_req),
        .pick_index  (pick_index),
        .pick_ack    (pick_ack),
        .pick_result (pick_result),
        .ctl_we      (ctl_we),
        .ctl_addr    (ctl_addr),
        .ctl_raddr   (ctl_raddr),
        .ctl_data    (ctl_data),
        .ctl_rdata   (ctl_rdata),
        .game_over   (game_over)
    );

endmodule

// File: sim/memory_game_tb.sv
module memory_game_tb;

    timeunit 1ns;
    timeprecision 100ps;

    // Run length that also sets the cycle limit
    localparam int num_games   = 3;
    localparam int max_picks   = 80;
    localparam int pick_cycles = 30;
    localparam int cycle_limit = num_games * ((max_picks + 5) * pick_cycles + 100) + 100;

    logic              clk;
    logic              rst;
    logic              new_game;
    logic              pick_req;
    mg_pkg::addr_t     pick_index;
    mg_pkg::addr_t     view_addr;
    logic              pick_ack;
    logic [1:0]        pick_result;
    logic              dealing;
    mg_pkg::reg_word_t view_data;
    logic              game_over;

    // Reference state with LFSR copy, board words and the held first pick
    logic [3:0]        lfsr_m;
    mg_pkg::reg_word_t board [0:12];
    mg_pkg::reg_word_t seen [0:12];
    logic              have_first;
    mg_pkg::addr_t     first_idx;
    logic [31:0]       rng;
    int                value_errors;
    int                other_errors;
    int                cycles;
    int                picks;
    mg_pkg::addr_t     next_idx;

    memory_game_top UUT (
        .clk         (clk),
        .rst         (rst),
        .new_game    (new_game),
        .pick_req    (pick_req),
        .pick_index  (pick_index),
        .view_addr   (view_addr),
        .pick_ack    (pick_ack),
        .pick_result (pick_result),
        .dealing     (dealing),
        .view_data   (view_data),
        .game_over   (game_over)
    );

    //////////////////////////////
    // Clock, LFSR copy, cycle limit
    //////////////////////////////

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Shift right with bit0 xor bit1 into bit3
    function automatic logic [3:0] lfsr_step(input logic [3:0] v);
        return {v[0] ^ v[1], v[3:1]};
    endfunction

    // Free running from reset and never reseeded by new_game
    always @(posedge clk) begin
        lfsr_m <= rst ? mg_pkg::lfsr_seed : lfsr_step(lfsr_m);
    end

    initial begin
        for (cycles = 0; cycles < cycle_limit; cycles++) begin
            @(posedge clk);
        end
        $display("Run stopped at the cycle limit of %0d", cycle_limit);
        print_counts();
        $display("TEST FAILED");
        $finish;
    end

    //////////////////////////////
    // Helpers
    //////////////////////////////

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Value in 0 to n-1 from the upper LCG bits
    task automatic draw(input int n, output int v);
        rng = lcg_next(rng);
        v   = int'(rng[31:16]) % n;
    endtask

    // LFSR value to pair colour
    function automatic logic [11:0] pair_colour(input logic [3:0] v);
        case (v)
            4'd1, 4'd2:   return mg_pkg::colour_green;
            4'd3, 4'd4:   return mg_pkg::colour_yellow;
            4'd5, 4'd6:   return mg_pkg::colour_red;
            4'd7, 4'd8:   return mg_pkg::colour_blue;
            4'd9, 4'd10:  return mg_pkg::colour_magenta;
            4'd11, 4'd12: return mg_pkg::colour_mint;
            default:      return 12'h000;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        assert (got == expected) else begin
            value_errors++;
            $display("FAILED %s: got %h expected %h", name, got, expected);
        end
    endtask

    task automatic print_counts();
        $display("Errors: %0d wrong values, %0d other failures", value_errors, other_errors);
    endtask

    // Reads all sixteen view addresses where 13 to 15 must read zero
    task automatic check_board();
        mg_pkg::reg_word_t exp;
        for (int a = 0; a < 16; a++) begin
            @(negedge clk);
            view_addr = 4'(a);
            #1;
            exp = (a <= 12) ? board[a] : '0;
            if (a <= 12) begin
                seen[a] = view_data;
            end
            assert (view_data == exp) else begin
                value_errors++;
                $display("FAILED view_data[%0d]: got %h expected %h", a, view_data, exp);
            end
        end
    endtask

    //////////////////////////////
    // New game and deal
    //////////////////////////////

    task automatic start_game();
        logic [3:0] v;
        int         n;
        int         valid;
        int         cnt;
        @(negedge clk);
        // Layout follows from the LFSR value after this edge onwards
        v     = lfsr_m;
        n     = 0;
        valid = 0;
        while (valid < 12) begin
            v = lfsr_step(v);
            n++;
            if ((v >= 4'd1) && (v <= mg_pkg::num_cards)) begin
                valid++;
                board[valid]             = '0;
                board[valid].card.colour = pair_colour(v);
                board[valid].card.active = 1'b1;
            end
        end
        board[0]   = '0;
        have_first = 1'b0;
        new_game   = 1'b1;
        @(negedge clk);
        new_game = 1'b0;
        cnt      = 0;
        while (dealing && (cnt < 20)) begin
            cnt++;
            @(negedge clk);
        end
        // One cycle per LFSR step up to the twelfth write
        check_value("dealing cycles", 32'(cnt), 32'(n));
        check_value("game_over", 32'(game_over), 32'd0);
        check_board();
        for (int c = 1; c <= 12; c += 2) begin
            cnt = 0;
            for (int a = 1; a <= 12; a++) begin
                if (seen[a].card.colour == pair_colour(4'(c))) begin
                    cnt++;
                end
            end
            check_value("cards per colour", 32'(cnt), 32'd2);
        end
    endtask

    //////////////////////////////
    // One pick over the handshake
    //////////////////////////////

    task automatic do_pick(input mg_pkg::addr_t idx);
        logic [1:0] exp_res;
        int         cnt;
        if ((idx < 4'd1) || (idx > mg_pkg::num_cards) || !board[idx].card.active ||
            (have_first && (idx == first_idx))) begin
            exp_res = mg_pkg::pick_rejected;
        end else if (!have_first) begin
            exp_res = mg_pkg::pick_first;
        end else if (board[idx].card.colour == board[first_idx].card.colour) begin
            exp_res = mg_pkg::pick_match;
        end else begin
            exp_res = mg_pkg::pick_mismatch;
        end
        @(negedge clk);
        pick_req   = 1'b1;
        pick_index = idx;
        cnt        = 0;
        do begin
            @(negedge clk);
            cnt++;
        end while (!pick_ack && (cnt < 10));
        assert (pick_ack) else begin
            other_errors++;
            $display("No acknowledge for the pick of card %0d", idx);
        end
        // Req sampled at edge 0 and ack set at edge 3 shows at the fourth falling edge
        check_value("pick_ack latency", 32'(cnt), 32'd4);
        check_value("pick_result", 32'(pick_result), 32'(exp_res));
        case (exp_res)
            mg_pkg::pick_first: begin
                board[idx].card.discovered = 1'b1;
                have_first                 = 1'b1;
                first_idx                  = idx;
            end
            mg_pkg::pick_match: begin
                board[idx].card.discovered       = 1'b1;
                board[idx].card.active           = 1'b0;
                board[first_idx].card.discovered = 1'b1;
                board[first_idx].card.active     = 1'b0;
                board[0].status.pairs            = board[0].status.pairs + 4'd1;
            end
            mg_pkg::pick_mismatch: begin
                board[idx].card.discovered       = 1'b0;
                board[first_idx].card.discovered = 1'b0;
            end
            default: ;
        endcase
        if ((exp_res == mg_pkg::pick_match) || (exp_res == mg_pkg::pick_mismatch)) begin
            have_first = 1'b0;
            if (board[0].status.moves != mg_pkg::moves_max) begin
                board[0].status.moves = board[0].status.moves + 8'd1;
            end
        end
        // Board is read while req is still held, so ack must stay up
        check_board();
        check_value("pick_ack held", 32'(pick_ack), 32'd1);
        check_value("pick_result held", 32'(pick_result), 32'(exp_res));
        check_value("game_over", 32'(game_over), 32'(board[0].status.pairs == mg_pkg::num_pairs));
        @(negedge clk);
        pick_req = 1'b0;
        @(negedge clk);
        check_value("pick_ack release", 32'(pick_ack), 32'd0);
    endtask

    // Mostly the partner of the held card and sometimes a bad or random index
    task automatic choose_pick(output mg_pkg::addr_t idx);
        int r;
        int s;
        int a;
        idx = '0;
        draw(16, r);
        if (r < 2) begin
            draw(16, s);
            idx = 4'(s);
        end else if (have_first && (r == 2)) begin
            idx = first_idx;
        end else if (have_first && (r < 12)) begin
            for (int k = 1; k <= 12; k++) begin
                if (board[k].card.active && (4'(k) != first_idx) &&
                    (board[k].card.colour == board[first_idx].card.colour)) begin
                    idx = 4'(k);
                end
            end
        end else begin
            draw(12, s);
            for (int k = 11; k >= 0; k--) begin
                a = ((s + k) % 12) + 1;
                if (board[a].card.active && !(have_first && (4'(a) == first_idx))) begin
                    idx = 4'(a);
                end
            end
        end
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial begin
        rst          = 1'b1;
        new_game     = 1'b0;
        pick_req     = 1'b0;
        pick_index   = '0;
        view_addr    = '0;
        rng          = 32'h0798_6092;
        have_first   = 1'b0;
        first_idx    = '0;
        value_errors = 0;
        other_errors = 0;
        for (int a = 0; a <= 12; a++) begin
            board[a] = '0;
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        // Empty board straight after reset
        check_value("pick_ack", 32'(pick_ack), 32'd0);
        check_value("dealing", 32'(dealing), 32'd0);
        check_value("game_over", 32'(game_over), 32'd0);
        check_board();
        for (int g = 0; g < num_games; g++) begin
            start_game();
            do_pick(4'd0);
            do_pick(4'd14);
            // Card 1 as first pick and then picked again
            do_pick(4'd1);
            do_pick(4'd1);
            picks = 0;
            while ((board[0].status.pairs != mg_pkg::num_pairs) && (picks < max_picks)) begin
                choose_pick(next_idx);
                do_pick(next_idx);
                picks++;
            end
            // Every card is removed once all pairs are found
            do_pick(4'd1);
            assert (game_over) else begin
                other_errors++;
                $display("Game %0d did not end within %0d picks", g, max_picks);
            end
        end
        print_counts();
        if ((value_errors + other_errors) == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: compile.f
hdl/mg_pkg.sv
hdl/card_dealer.sv
hdl/card_regfile.sv
hdl/game_control.sv
hdl/memory_game_top.sv
sim/memory_game_tb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f compile.f --top-module memory_game_tb -o memory_game_sim
	./obj_dir/memory_game_sim > sim.log 2>&1; cat sim.log
	grep -q "TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
